/* project.f */
+incdir+hdl
+incdir+testbench
hdl/cpuPkg.sv
hdl/cpuIfs.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/dataMem.sv
hdl/coreTop.sv
testbench/tbCore.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator, result judged from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f project.f --top-module tbCore -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }

grep -q "ERRORS FOUND" sim.log && { echo "simulation reported failures"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

/* testbench/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] mReg [16];
logic [31:0] mMem [256];
logic [3:0]  mFlags;     // n z c v

// Expected pulses in issue order, kind 1 is a branch
logic        kindQ [$];
logic [3:0]  regQ  [$];
logic [31:0] dataQ [$];
logic [3:0]  flagQ [$];
logic        chkQ  [$];

task automatic pushEvent(input logic k, input logic [3:0] r, input logic [31:0] d,
                         input logic chk);
    kindQ.push_back(k);
    regQ.push_back(r);
    dataQ.push_back(d);
    flagQ.push_back(mFlags);
    chkQ.push_back(chk);
endtask

task automatic writeModel(input logic [3:0] d, input logic [31:0] val, input logic chk);
    if (d != 4'd0) begin
        mReg[d] = val;
        pushEvent(1'b0, d, val, chk);
    end
endtask

task automatic modelExec(input logic [31:0] ins);
    logic [1:0]  c;
    logic [3:0]  s;
    logic [3:0]  d;
    logic [3:0]  a;
    logic        sf;
    logic [15:0] im;
    logic [31:0] ext;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [32:0] wide;
    logic [31:0] res;
    logic [7:0]  ad;
    logic        v;
    {c, s, d, a, sf} = ins[31:17];
    im  = ins[15:0];
    ext = {{16{im[15]}}, im};
    opA = mReg[a];
    if (c == CLS_MOVI && s == SUB_MOV) begin
        writeModel(d, ext, 1'b1);
    end else if ((c == CLS_MOVI || c == CLS_ALUR) && (s == SUB_ADDS || s == SUB_SUBS)) begin
        opB = (c == CLS_MOVI) ? ext : mReg[im[3:0]];
        if (s == SUB_ADDS) begin
            wide = {1'b0, opA} + {1'b0, opB};
            v    = (opA[31] == opB[31]) && (wide[31] != opA[31]);
        end else begin
            wide = {1'b0, opA} + {1'b0, ~opB} + 33'd1; // Carry out is not-borrow
            v    = (opA[31] != opB[31]) && (wide[31] != opA[31]);
        end
        res = wide[31:0];
        if (sf) mFlags = {res[31], res == 32'd0, wide[32], v};
        writeModel(d, res, 1'b1);
    end else if (c == CLS_MEM) begin
        ad = opA[7:0] + im[7:0]; // Low byte of base plus offset
        if (s == SUB_STR) mMem[ad] = mReg[d];
        else if (s == SUB_LDR) writeModel(d, mMem[ad], 1'b0);
    end else if (c == CLS_BR) begin
        if ((s == SUB_BEQ && mFlags[2]) || (s == SUB_BNE && !mFlags[2]))
            pushEvent(1'b1, 4'd0, {16'd0, im}, 1'b0);
    end
endtask

`endif

/* testbench/tbCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbCore;
    import cpuPkg::*;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic        wbValid;
    logic [3:0]  wbReg;
    logic [31:0] wbData;
    flagsT       flags;
    logic        branchTaken;
    logic [15:0] branchOffset;

    integer      seed = 63378;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errAtStart = 0;
    string       curTest = "reset";
    logic        flagPend = 1'b0;
    logic [3:0]  flagExp;
    logic        eKind;
    logic [3:0]  eReg;
    logic [31:0] eData;
    logic [3:0]  eFlags;
    logic        eChk;

    `include "tbModel.svh"

    coreTop dut0 (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instr        (instr),
        .wbValid      (wbValid),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .flags        (flags),
        .branchTaken  (branchTaken),
        .branchOffset (branchOffset)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expV, input logic [31:0] actV);
        checks++;
        if (expV !== actV) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expV, actV);
        end
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] mk(input logic [1:0] c, input logic [3:0] s,
                                       input logic [3:0] d, input logic [3:0] a,
                                       input logic sf, input logic [15:0] im);
        return {c, s, d, a, sf, 1'b0, im};
    endfunction

    task automatic issue(input logic [31:0] x);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= x;
        modelExec(x);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instrValid <= 1'b0;
        end
    endtask

    // Bounded wait for every queued pulse
    task automatic finishTest();
        int n;
        n = 0;
        idle(1);
        while (kindQ.size() > 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (kindQ.size() > 0) begin
            errors++;
            $display("%s: %0d expected pulses never arrived", curTest, kindQ.size());
            kindQ.delete();
            regQ.delete();
            dataQ.delete();
            flagQ.delete();
            chkQ.delete();
        end
        repeat (2) @(negedge clk);
        tests++;
        $display("test %s finished with %0d errors", curTest, errors - errAtStart);
        errAtStart = errors;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (flagPend) begin
                check({curTest, " flags"}, {28'd0, flagExp}, {28'd0, flags});
                flagPend = 1'b0;
            end
            if (wbValid || branchTaken) begin
                if (kindQ.size() == 0) begin
                    errors++;
                    $display("%s: unexpected pulse, wbValid %0b branchTaken %0b",
                             curTest, wbValid, branchTaken);
                end else begin
                    eKind  = kindQ.pop_front();
                    eReg   = regQ.pop_front();
                    eData  = dataQ.pop_front();
                    eFlags = flagQ.pop_front();
                    eChk   = chkQ.pop_front();
                    check({curTest, " branchTaken"}, {31'd0, eKind}, {31'd0, branchTaken});
                    if (!eKind) begin
                        check({curTest, " wbReg"}, {28'd0, eReg}, {28'd0, wbReg});
                        check({curTest, " wbData"}, eData, wbData);
                        flagPend = eChk;
                        flagExp  = eFlags;
                    end else begin
                        check({curTest, " branchOffset"}, eData, {16'd0, branchOffset});
                    end
                end
            end
        end
    end

    initial begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = 32'd0;
        mFlags     = 4'd0;
        for (int r = 0; r < 16; r++) mReg[r] = 32'd0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        repeat (4) begin // Quiet outputs straight after reset
            @(negedge clk);
            check("reset wbValid", 32'd0, {31'd0, wbValid});
            check("reset branchTaken", 32'd0, {31'd0, branchTaken});
            check("reset flags", 32'd0, {28'd0, flags});
        end
        for (int r = 1; r < 16; r++) issue(mk(CLS_MOVI, SUB_ADDS, 4'(r), 4'(r), 1'b0, 16'd0));
        finishTest();

        curTest = "mov";
        for (int i = 0; i < 20; i++)
            issue(mk(CLS_MOVI, SUB_MOV, 4'(i == 5 ? 0 : 1 + rnd(15)), 4'(rnd(16)), 1'b0,
                     16'($random(seed))));
        finishTest();

        curTest = "arith";
        for (int i = 0; i < 60; i++) begin
            issue(mk(rnd(2) ? CLS_ALUR : CLS_MOVI, rnd(2) ? SUB_SUBS : SUB_ADDS,
                     4'(1 + rnd(15)), 4'(rnd(16)), 1'(rnd(2)), 16'($random(seed))));
            if (rnd(4) == 0) idle(1);
        end
        finishTest();

        curTest = "edge";
        issue(mk(CLS_MOVI, SUB_MOV, 4'd1, 4'd0, 1'b0, 16'hFFFF)); // All ones
        issue(mk(CLS_MOVI, SUB_MOV, 4'd2, 4'd0, 1'b0, 16'h7FFF));
        issue(mk(CLS_MOVI, SUB_MOV, 4'd3, 4'd0, 1'b0, 16'd1));
        for (int i = 0; i < 31; i++) // Doubling up to the signed minimum
            issue(mk(CLS_ALUR, SUB_ADDS, 4'd3, 4'd3, 1'b1, 16'd3));
        for (int a = 1; a < 4; a++)
            for (int b = 1; b < 4; b++) begin
                issue(mk(CLS_ALUR, SUB_ADDS, 4'(8 + rnd(7)), 4'(a), 1'b1, 16'(b)));
                issue(mk(CLS_ALUR, SUB_SUBS, 4'(8 + rnd(7)), 4'(a), 1'b1, 16'(b)));
            end
        finishTest();

        curTest = "mem";
        for (int i = 0; i < 12; i++) begin
            int base;
            int off;
            base = 1 + rnd(7);
            off  = rnd(64) - 32;
            issue(mk(CLS_MOVI, SUB_MOV, 4'(base), 4'd0, 1'b0, 16'(rnd(256))));
            issue(mk(CLS_MOVI, SUB_MOV, 4'd8, 4'd0, 1'b0, 16'($random(seed))));
            issue(mk(CLS_MEM, SUB_STR, 4'd8, 4'(base), 1'b0, 16'(off)));
            issue(mk(CLS_MEM, SUB_LDR, 4'(12 + rnd(4)), 4'(base), 1'b0, 16'(off)));
            idle(1); // Load-use gap
        end
        finishTest();

        curTest = "branch";
        for (int i = 0; i < 30; i++) begin
            int a;
            a = 1 + rnd(15);
            issue(mk(CLS_ALUR, SUB_SUBS, 4'(1 + rnd(15)), 4'(a), 1'b1,
                     16'(rnd(2) ? a : 1 + rnd(15))));
            if (rnd(3) == 0)
                issue(mk(CLS_MOVI, SUB_ADDS, 4'(1 + rnd(15)), 4'(rnd(16)), 1'b0, 16'(rnd(9))));
            issue(mk(CLS_BR, rnd(2) ? SUB_BEQ : SUB_BNE, 4'd0, 4'd0, 1'b0, 16'($random(seed))));
            idle(rnd(2));
        end
        finishTest();

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuParams.svh"

module coreTop (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instrValid,
    input  logic [31:0]                   instr,
    output logic                          wbValid,
    output logic [$clog2(`REG_COUNT)-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0]        wbData,
    output cpuPkg::flagsT                 flags,
    output logic                          branchTaken,
    output logic [15:0]                   branchOffset
);
    logic [$clog2(`REG_COUNT)-1:0] rdAddrA;
    logic [$clog2(`REG_COUNT)-1:0] rdAddrB;
    logic [`DATA_WIDTH-1:0]        rdDataA;
    logic [`DATA_WIDTH-1:0]        rdDataB;
    logic                          memWrite;
    logic                          memRead;
    logic [$clog2(`MEM_DEPTH)-1:0] memAddr;
    logic [`DATA_WIDTH-1:0]        memWData;
    logic [`DATA_WIDTH-1:0]        memRData;

    execOpIf   opBus ();
    regWriteIf wbBus ();

    instrDecode decode0 (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .wbMon      (wbBus),
        .op         (opBus)
    );

    regFile regs0 (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wr      (wbBus)
    );

    executeUnit exec0 (
        .clk          (clk),
        .rst          (rst),
        .op           (opBus),
        .wr           (wbBus),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memAddr      (memAddr),
        .memWData     (memWData),
        .memRData     (memRData),
        .flags        (flags),
        .branchTaken  (branchTaken),
        .branchOffset (branchOffset)
    );

    dataMem mem0 (
        .clk      (clk),
        .memWrite (memWrite),
        .memRead  (memRead),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRData (memRData)
    );

    // Write-back report straight off the register write bus
    assign wbValid = wbBus.en;
    assign wbReg   = wbBus.addr;
    assign wbData  = wbBus.data;

endmodule

`default_nettype wire

/* hdl/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuParams.svh"

module dataMem (
    input  logic                          clk,
    input  logic                          memWrite,
    input  logic                          memRead,
    input  logic [$clog2(`MEM_DEPTH)-1:0] memAddr,
    input  logic [`DATA_WIDTH-1:0]        memWData,
    output logic [`DATA_WIDTH-1:0]        memRData
);
    logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr] <= memWData;
        end
        if (memRead) begin
            memRData <= mem[memAddr]; // Valid the cycle after memRead
        end
    end

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuParams.svh"

module executeUnit (
    input  logic                          clk,
    input  logic                          rst,
    execOpIf.sink                         op,
    regWriteIf.src                        wr,
    output logic                          memWrite,
    output logic                          memRead,
    output logic [$clog2(`MEM_DEPTH)-1:0] memAddr,
    output logic [`DATA_WIDTH-1:0]        memWData,
    input  logic [`DATA_WIDTH-1:0]        memRData,
    output cpuPkg::flagsT                 flags,
    output logic                          branchTaken,
    output logic [15:0]                   branchOffset
);
    import cpuPkg::*;

    localparam int dataW = `DATA_WIDTH;

    logic                          isArith;
    logic                          isSub;
    logic                          isMov;
    logic                          isStr;
    logic                          isLdr;
    logic [dataW-1:0]              immExt;
    logic [dataW:0]                sum;
    logic [dataW-1:0]              aluRes;
    logic [dataW-1:0]              addrFull;
    flagsT                         nextFlags;
    logic                          ldPend;
    logic [$clog2(`REG_COUNT)-1:0] ldDest;

    assign isArith = ((op.cls == CLS_MOVI) || (op.cls == CLS_ALUR))
                     && ((op.subOp == SUB_ADDS) || (op.subOp == SUB_SUBS));
    assign isSub   = op.subOp == SUB_SUBS;
    assign isMov   = (op.cls == CLS_MOVI) && (op.subOp == SUB_MOV);
    assign isStr   = (op.cls == CLS_MEM) && (op.subOp == SUB_STR);
    assign isLdr   = (op.cls == CLS_MEM) && (op.subOp == SUB_LDR);

    assign immExt = {{(dataW-16){op.imm[15]}}, op.imm};
    assign sum    = isSub ? ({1'b0, op.opA} - {1'b0, op.opB})
                          : ({1'b0, op.opA} + {1'b0, op.opB});
    assign aluRes = isMov ? immExt : sum[dataW-1:0];

    always_comb begin
        nextFlags.n = aluRes[dataW-1];
        nextFlags.z = aluRes == '0;
        nextFlags.c = isSub ? ~sum[dataW] : sum[dataW];
        // Operand signs agree for add, differ for sub, and the result sign flips
        nextFlags.v = ((op.opA[dataW-1] ^ op.opB[dataW-1]) == isSub)
                      && (aluRes[dataW-1] != op.opA[dataW-1]);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags  <= '0;
            ldPend <= 1'b0;
        end else begin
            if (op.valid && isArith && op.setFlags) begin
                flags <= nextFlags;
            end
            ldPend <= memRead && (op.dest != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (memRead) begin
            ldDest <= op.dest;
        end
    end

    assign addrFull = op.opA + immExt;
    assign memAddr  = addrFull[$clog2(`MEM_DEPTH)-1:0]; // Wraps at memory depth
    assign memWData = op.opB;
    assign memWrite = op.valid && isStr;
    assign memRead  = op.valid && isLdr;

    always_comb begin
        wr.en   = 1'b0;
        wr.addr = op.dest;
        wr.data = aluRes;
        if (ldPend) begin // Returning load owns the port
            wr.en   = 1'b1;
            wr.addr = ldDest;
            wr.data = memRData;
        end else if (op.valid && (isArith || isMov) && (op.dest != '0)) begin
            wr.en = 1'b1;
        end
    end

    // Z comes from the registered flags, which already hold a preceding ADDS or SUBS
    assign branchTaken  = op.valid && (op.cls == CLS_BR)
                          && (((op.subOp == SUB_BEQ) && flags.z)
                           || ((op.subOp == SUB_BNE) && !flags.z));
    assign branchOffset = op.imm;

    // A returning load and a new result cannot share the write port
    assert property (@(posedge clk) disable iff (rst)
        ldPend |-> !(op.valid && (isArith || isMov) && (op.dest != '0)));

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuParams.svh"

module regFile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(`REG_COUNT)-1:0] rdAddrA,
    input  logic [$clog2(`REG_COUNT)-1:0] rdAddrB,
    output logic [`DATA_WIDTH-1:0]        rdDataA,
    output logic [`DATA_WIDTH-1:0]        rdDataB,
    regWriteIf.sink                       wr
);
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data; // R0 stays zero
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

/* hdl/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuParams.svh"

module instrDecode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instrValid,
    input  logic [31:0]                   instr,
    output logic [$clog2(`REG_COUNT)-1:0] rdAddrA,
    output logic [$clog2(`REG_COUNT)-1:0] rdAddrB,
    input  logic [`DATA_WIDTH-1:0]        rdDataA,
    input  logic [`DATA_WIDTH-1:0]        rdDataB,
    regWriteIf.mon                        wbMon,
    execOpIf.src                          op
);
    import cpuPkg::*;

    logic                   validQ;
    logic [31:0]            instrQ;
    instrT                  ins;
    logic [`DATA_WIDTH-1:0] immExt;
    logic                   fwdA;
    logic                   fwdB;
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            instrQ <= instr;
        end
    end

    assign ins    = instrT'(instrQ);
    assign immExt = {{(`DATA_WIDTH-16){ins.imm[15]}}, ins.imm};

    assign rdAddrA = ins.srcA;
    assign rdAddrB = (ins.cls == CLS_MEM) ? ins.dest : ins.imm[3:0]; // Store data via port B

    // Result being written this cycle bypasses the register file
    assign fwdA = wbMon.en && (wbMon.addr != '0) && (wbMon.addr == rdAddrA);
    assign fwdB = wbMon.en && (wbMon.addr != '0) && (wbMon.addr == rdAddrB);
    assign opA  = fwdA ? wbMon.data : rdDataA;
    assign opB  = (ins.cls == CLS_MOVI) ? immExt : (fwdB ? wbMon.data : rdDataB);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= validQ;
        end
    end

    always_ff @(posedge clk) begin
        if (validQ) begin
            op.cls      <= ins.cls;
            op.subOp    <= ins.subOp;
            op.dest     <= ins.dest;
            op.setFlags <= ins.setFlags;
            op.imm      <= ins.imm;
            op.opA      <= opA;
            op.opB      <= opB;
        end
    end

    // Loaded word is not back in time for the instruction right behind the load
    assert property (@(posedge clk) disable iff (rst)
        validQ && op.valid && (op.cls == CLS_MEM) && (op.subOp == SUB_LDR)
        && (op.dest != '0) && (ins.cls != CLS_BR) && (ins.subOp != SUB_MOV)
        |-> (rdAddrA != op.dest));

endmodule

`default_nettype wire

/* hdl/cpuIfs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuParams.svh"

// Decoded operation, one strobe per instruction and no back-pressure
interface execOpIf;
    import cpuPkg::*;

    logic                          valid;
    opClassE                       cls;
    subOpE                         subOp;
    logic [$clog2(`REG_COUNT)-1:0] dest;
    logic                          setFlags;
    logic [15:0]                   imm;
    logic [`DATA_WIDTH-1:0]        opA;
    logic [`DATA_WIDTH-1:0]        opB; // Store data for STR

    modport src (
        output valid, cls, subOp, dest, setFlags, imm, opA, opB
    );

    modport sink (
        input valid, cls, subOp, dest, setFlags, imm, opA, opB
    );
endinterface

interface regWriteIf;
    logic                          en;
    logic [$clog2(`REG_COUNT)-1:0] addr;
    logic [`DATA_WIDTH-1:0]        data;

    modport src (
        output en, addr, data
    );

    modport sink (
        input en, addr, data
    );

    modport mon (
        input en, addr, data // Forwarding tap
    );
endinterface

`default_nettype wire

/* hdl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef enum logic [1:0] {
        CLS_MOVI = 2'b00, // Immediate arithmetic
        CLS_ALUR = 2'b01, // Register arithmetic
        CLS_MEM  = 2'b10,
        CLS_BR   = 2'b11
    } opClassE;

    // Pairs not decoded by the execute unit act as no-ops
    typedef enum logic [3:0] {
        SUB_MOV  = 4'h0,
        SUB_STR  = 4'h1,
        SUB_LDR  = 4'h2,
        SUB_BEQ  = 4'h4,
        SUB_BNE  = 4'h5,
        SUB_ADDS = 4'h9,
        SUB_SUBS = 4'hA
    } subOpE;

    typedef struct packed {
        logic n;
        logic z;
        logic c; // Not-borrow on subtract
        logic v;
    } flagsT;

    // Bit 31 down to bit 0
    typedef struct packed {
        opClassE     cls;
        subOpE       subOp;
        logic [3:0]  dest;
        logic [3:0]  srcA;
        logic        setFlags;
        logic        spare;
        logic [15:0] imm; // Low nibble doubles as source B
    } instrT;

endpackage

`default_nettype wire

/* hdl/cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Core sizing

`define DATA_WIDTH 32  // Word size
`define REG_COUNT  16  // Includes the hardwired zero register
`define MEM_DEPTH  256 // Words, not bytes

`endif
